//--- hbridge_ctrl.f
hdl/hbridge_pkg.sv
hdl/adc_frontend.sv
hdl/startup_timer.sv
hdl/startup_fsm.sv
hdl/dead_time.sv
hdl/bridge_gate.sv
hdl/hbridge_top.sv
verif/tb_clock_gen.sv
verif/tb_hbridge_top.sv

//--- hdl/adc_frontend.sv
/*
 * tank adc channel capture: polarity inversion,
 * over-range saturation and offset-binary dac monitor code
 */
`timescale 1ns/1ns

module adc_frontend (
   input  logic                                 ADA_DCO,
   input  logic                                 i_rst_n,
   input  logic signed [hbridge_pkg::ADC_W-1:0] i_data,   // raw two's complement
   input  logic                                 i_or,     // over-range from the adc
   output hbridge_pkg::adc_sample_t             o_sample
);

   localparam int W = hbridge_pkg::ADC_W;

   localparam logic [W-1:0] POS_MAX = {1'b0, {(W-1){1'b1}}};  // 0x1fff
   localparam logic [W-1:0] NEG_MAX = {1'b1, {(W-1){1'b0}}};  // 0x2000
   localparam logic [W-1:0] DAC_OFS = W'(hbridge_pkg::DAC_MID);

   logic signed [W-1:0] neg_data;   // board inverts the sense
   logic signed [W-1:0] sat_data;
   logic        [W-1:0] dac_code;

   // --------------------------------------------------
   // combinational conversion
   // --------------------------------------------------
   assign neg_data = -i_data;

   always_comb begin
      if (i_or) begin
         // clipped sample, push to the rail of the true sign
         if (i_data == NEG_MAX) begin
            sat_data = POS_MAX;      // -full scale inverts to +full scale
         end else begin
            sat_data = NEG_MAX;
         end
      end else begin
         sat_data = neg_data;
      end
   end

   // dac copy ignores over-range, wraps mod 2^W
   assign dac_code = neg_data + DAC_OFS;

   // one register stage, valid one cycle after the input
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_sample <= '0;
      end else begin
         o_sample.data <= sat_data;
         o_sample.dac  <= dac_code;
      end
   end

endmodule

//--- hdl/bridge_gate.sv
/*
 * gate pattern by start-up state, shoot-through guard,
 * enable gating and the registered mosfet drives
 */
`timescale 1ns/1ns

module bridge_gate (
   input  logic                   ADA_DCO,
   input  logic                   i_rst_n,
   input  logic                   i_enable,
   input  hbridge_pkg::su_state_t i_state,
   input  hbridge_pkg::bridge_t   i_cmd_dt,   // dead-time corrected command
   output hbridge_pkg::bridge_t   o_q
);

   hbridge_pkg::bridge_t pat;      // pattern for the current state
   hbridge_pkg::bridge_t run_pat;  // guarded run pattern
   logic                 short_leg;

   // both switches of a leg on, never pass that
   assign short_leg = (i_cmd_dt.q1 && i_cmd_dt.q3) || (i_cmd_dt.q2 && i_cmd_dt.q4);
   assign run_pat   = short_leg ? '0 : i_cmd_dt;

   always_comb begin
      pat = '0;                            // IDLE, all off
      case (i_state)
         hbridge_pkg::ST_BOOT: begin
            pat.q3 = 1'b1;                 // low sides charge bootstrap caps
            pat.q4 = 1'b1;
         end
         hbridge_pkg::ST_FORCE: begin
            pat.q1 = 1'b1;                 // sigma=1
            pat.q4 = 1'b1;
         end
         hbridge_pkg::ST_RUN: begin
            pat = run_pat;
         end
         default: begin
            pat = '0;
         end
      endcase
   end

   // --------------------------------------------------
   // output register
   // --------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_q <= '0;
      end else begin
         o_q <= pat & {4{i_enable}};   // enable low kills all drives
      end
   end

   // no leg ever shorted at the pins, whatever the state and command
   a_no_shoot_through : assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      !(o_q.q1 && o_q.q3) && !(o_q.q2 && o_q.q4))
      else $error("shoot-through on the bridge outputs");

endmodule

//--- hdl/dead_time.sv
/*
 * dead-time insertion on four switch commands,
 * delayed turn-on from four selectable values, immediate turn-off
 */
`timescale 1ns/1ns

module dead_time #(
   parameter int DT0 = 10,
   parameter int DT1 = 20,
   parameter int DT2 = 40,
   parameter int DT3 = 60
) (
   input  logic                 ADA_DCO,
   input  logic                 i_rst_n,
   input  hbridge_pkg::bridge_t i_cmd,     // from the control law
   input  hbridge_pkg::dt_sel_t i_dt_sel,
   output hbridge_pkg::bridge_t o_cmd_dt
);

   localparam int CW = hbridge_pkg::CNT_W;

   logic [CW-1:0] dt_load;   // selected dead time in cycles
   logic [3:0]    cmd_v;
   logic [3:0]    out_v;

   // --------------------------------------------------
   // dead time select
   // --------------------------------------------------
   always_comb begin
      case (i_dt_sel)
         2'd0:    dt_load = CW'(DT0);
         2'd1:    dt_load = CW'(DT1);
         2'd2:    dt_load = CW'(DT2);
         default: dt_load = CW'(DT3);
      endcase
   end

   assign cmd_v = i_cmd;

   // --------------------------------------------------
   // one down-counter per switch
   // --------------------------------------------------
   for (genvar i = 0; i < 4; i++) begin : g_sw
      logic [CW-1:0] cnt;
      logic          drv;

      always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
         if (!i_rst_n) begin
            cnt <= '0;          // empty after reset
            drv <= 1'b0;
         end else if (!cmd_v[i]) begin
            cnt <= dt_load;     // reload while off
            drv <= 1'b0;        // turn-off is immediate
         end else begin
            if (cnt != '0) begin
               cnt <= cnt - 1'b1;
            end
            // dead time elapsed on this edge or earlier
            drv <= (cnt <= CW'(1));
         end
      end

      assign out_v[i] = drv;
   end

   assign o_cmd_dt = out_v;

endmodule

//--- hdl/hbridge_pkg.sv
/*
 * shared widths, switch bundle and adc sample structs,
 * start-up state encoding and dead-time select type
 */
package hbridge_pkg;

   // --------------------------------------------------
   // widths and constants
   // --------------------------------------------------
   localparam int ADC_W   = 14;    // tank adc sample width
   localparam int DAC_MID = 8191;  // mid-scale of the monitor dac
   localparam int CNT_W   = 8;     // start-up and dead-time counters

   // one adc channel after the front end
   typedef struct packed {
      logic signed [ADC_W-1:0] data;  // polarity corrected, saturated
      logic        [ADC_W-1:0] dac;   // offset binary, for the dac copy
   } adc_sample_t;

   // four mosfet drives
   // leg 1 = q1 (high) / q3 (low), leg 2 = q2 (high) / q4 (low)
   typedef struct packed {
      logic q4;
      logic q3;
      logic q2;
      logic q1;
   } bridge_t;

   // --------------------------------------------------
   // start-up sequence
   // --------------------------------------------------
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,  // drives off
      ST_BOOT  = 2'd1,  // low sides on, bootstrap charge
      ST_FORCE = 2'd2,  // q1 + q4, sigma=1
      ST_RUN   = 2'd3   // external control law in charge
   } su_state_t;

   // index into DT0..DT3
   typedef logic [1:0] dt_sel_t;

endpackage

//--- hdl/hbridge_top.sv
/*
 * h-bridge power-stage front end: adc capture,
 * start-up sequence, dead time and gate drive
 */
`timescale 1ns/1ns

module hbridge_top #(
   parameter int BOOT_CYCLES  = 10,   // bootstrap charge length
   parameter int FORCE_CYCLES = 6,    // sigma=1 length
   parameter int DT0          = 10,   // dead times in clock cycles
   parameter int DT1          = 20,
   parameter int DT2          = 40,
   parameter int DT3          = 60
) (
   input  logic                                 ADA_DCO,
   input  logic                                 i_rst_n,
   // tank adcs
   input  logic signed [hbridge_pkg::ADC_W-1:0] i_ada_data,   // tank voltage
   input  logic signed [hbridge_pkg::ADC_W-1:0] i_adb_data,   // tank current
   input  logic                                 i_ada_or,
   input  logic                                 i_adb_or,
   // control
   input  logic                                 i_enable,
   input  hbridge_pkg::bridge_t                 i_cmd,        // external control law
   input  hbridge_pkg::dt_sel_t                 i_dt_sel,
   // outputs
   output hbridge_pkg::adc_sample_t             o_adc_a,
   output hbridge_pkg::adc_sample_t             o_adc_b,
   output hbridge_pkg::bridge_t                 o_q           // mosfet drives
);

   logic                   tmr_clr;
   logic                   tmr_en;
   logic                   boot_done;
   logic                   force_done;
   hbridge_pkg::su_state_t su_state;
   hbridge_pkg::bridge_t   cmd_dt;

   // --------------------------------------------------
   // adc channels
   // --------------------------------------------------
   adc_frontend adc_a_inst (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_data   (i_ada_data),
      .i_or     (i_ada_or),
      .o_sample (o_adc_a)
   );

   adc_frontend adc_b_inst (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_data   (i_adb_data),
      .i_or     (i_adb_or),
      .o_sample (o_adc_b)
   );

   // --------------------------------------------------
   // start-up
   // --------------------------------------------------
   startup_timer #(
      .BOOT_CYCLES  (BOOT_CYCLES),
      .FORCE_CYCLES (FORCE_CYCLES)
   ) startup_timer_inst (
      .ADA_DCO      (ADA_DCO),
      .i_rst_n      (i_rst_n),
      .i_clr        (tmr_clr),
      .i_en         (tmr_en),
      .o_boot_done  (boot_done),
      .o_force_done (force_done)
   );

   startup_fsm startup_fsm_inst (
      .ADA_DCO      (ADA_DCO),
      .i_rst_n      (i_rst_n),
      .i_enable     (i_enable),
      .i_boot_done  (boot_done),
      .i_force_done (force_done),
      .o_tmr_clr    (tmr_clr),
      .o_tmr_en     (tmr_en),
      .o_state      (su_state)
   );

   // --------------------------------------------------
   // gate path
   // --------------------------------------------------
   dead_time #(
      .DT0 (DT0),
      .DT1 (DT1),
      .DT2 (DT2),
      .DT3 (DT3)
   ) dead_time_inst (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_cmd    (i_cmd),
      .i_dt_sel (i_dt_sel),
      .o_cmd_dt (cmd_dt)
   );

   bridge_gate bridge_gate_inst (
      .ADA_DCO  (ADA_DCO),
      .i_rst_n  (i_rst_n),
      .i_enable (i_enable),
      .i_state  (su_state),
      .i_cmd_dt (cmd_dt),
      .o_q      (o_q)
   );

endmodule

//--- hdl/startup_fsm.sv
/*
 * start-up sequencer IDLE -> BOOT -> FORCE -> RUN,
 * steers the start-up timer and selects the gate mode
 */
`timescale 1ns/1ns

module startup_fsm (
   input  logic                   ADA_DCO,
   input  logic                   i_rst_n,
   input  logic                   i_enable,      // converter on/off level
   input  logic                   i_boot_done,
   input  logic                   i_force_done,
   output logic                   o_tmr_clr,
   output logic                   o_tmr_en,
   output hbridge_pkg::su_state_t o_state
);

   hbridge_pkg::su_state_t state;
   hbridge_pkg::su_state_t state_nxt;

   // --------------------------------------------------
   // next state
   // --------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         hbridge_pkg::ST_IDLE: begin
            if (i_enable) state_nxt = hbridge_pkg::ST_BOOT;
         end
         hbridge_pkg::ST_BOOT: begin
            if (i_boot_done) state_nxt = hbridge_pkg::ST_FORCE;
         end
         hbridge_pkg::ST_FORCE: begin
            if (i_force_done) state_nxt = hbridge_pkg::ST_RUN;
         end
         hbridge_pkg::ST_RUN: begin
            state_nxt = hbridge_pkg::ST_RUN;  // stays until enable drops
         end
         default: begin
            state_nxt = hbridge_pkg::ST_IDLE;
         end
      endcase
      if (!i_enable) begin
         state_nxt = hbridge_pkg::ST_IDLE;   // from any state
      end
   end

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= hbridge_pkg::ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // timer held at zero while disabled
   // the IDLE cycle that sees enable already counts as the first boot cycle
   assign o_tmr_clr = !i_enable;
   assign o_tmr_en  = i_enable && (state != hbridge_pkg::ST_RUN);

   assign o_state = state;

   // run mode only after the forced sigma=1 phase
   a_run_from_force : assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      (state == hbridge_pkg::ST_RUN && $past(state) != hbridge_pkg::ST_RUN)
      |-> $past(state) == hbridge_pkg::ST_FORCE)
      else $error("RUN entered without FORCE");

endmodule

//--- hdl/startup_timer.sv
/*
 * start-up cycle counter with boot and force phase-end flags
 */
`timescale 1ns/1ns

module startup_timer #(
   parameter int BOOT_CYCLES  = 10,
   parameter int FORCE_CYCLES = 6
) (
   input  logic ADA_DCO,
   input  logic i_rst_n,
   input  logic i_clr,          // wins over i_en
   input  logic i_en,
   output logic o_boot_done,
   output logic o_force_done
);

   localparam int CW = hbridge_pkg::CNT_W;
   localparam logic [CW-1:0] BOOT_END  = CW'(BOOT_CYCLES);
   localparam logic [CW-1:0] FORCE_END = CW'(BOOT_CYCLES + FORCE_CYCLES);

   logic [CW-1:0] cnt;

   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (i_clr) begin
         cnt <= '0;
      end else if (i_en && cnt != FORCE_END) begin
         cnt <= cnt + 1'b1;          // stops at the end of force
      end
   end

   assign o_boot_done  = (cnt >= BOOT_END);   // levels from the count register
   assign o_force_done = (cnt >= FORCE_END);

   // boot phase already over on the cycle before force ends
   a_force_after_boot : assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      $rose(o_force_done) |-> $past(o_boot_done))
      else $error("force_done rose while boot_done low");

endmodule

//--- verif/tb_clock_gen.sv
/*
 * free-running clock for the testbench
 */
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD = 10   // ns
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   // half period per toggle
   always #(PERIOD/2) o_clk = ~o_clk;

endmodule

//--- verif/tb_hbridge_top.sv
/*
 * testbench for hbridge_top with adc, start-up and dead-time reference models,
 * per-edge comparing process, directed sequences and timeout
 */
`timescale 1ns/1ns

module tb_hbridge_top;

   localparam int BOOT_CYCLES  = 10;
   localparam int FORCE_CYCLES = 6;
   localparam int DT0          = 10;
   localparam int DT1          = 20;
   localparam int DT2          = 40;
   localparam int DT3          = 60;
   localparam int MAX_CYCLES   = 3000;  // test needs well under half of this
   localparam int W            = hbridge_pkg::ADC_W;
   localparam int FS           = 2**(W-1);  // full-scale magnitude

   logic                        ADA_DCO;
   logic                        rst_n;
   logic signed [W-1:0]         ada_data;
   logic signed [W-1:0]         adb_data;
   logic                        ada_or;
   logic                        adb_or;
   logic                        enable;
   hbridge_pkg::bridge_t        cmd;
   hbridge_pkg::dt_sel_t        dt_sel;
   hbridge_pkg::adc_sample_t    adc_a;
   hbridge_pkg::adc_sample_t    adc_b;
   hbridge_pkg::bridge_t        q;
   logic [3:0]                  q_v;       // q as plain bits, q1 = bit 0

   // reference model state, owned by the comparing process
   hbridge_pkg::adc_sample_t    exp_a;
   hbridge_pkg::adc_sample_t    exp_b;
   hbridge_pkg::bridge_t        exp_q;
   hbridge_pkg::bridge_t        q_next;
   logic [3:0]                  drv_v;     // modeled dead-time output
   logic [3:0]                  cmd_v;
   int                          hi_cnt [4];
   int                          dt_lat [4];
   int                          en_cnt;

   int                          errors = 0;
   int                          checks = 0;
   int                          cycles = 0;
   integer                      seed   = 58679;

   assign q_v = q;

   tb_clock_gen #(.PERIOD(10)) clock_gen_inst (.o_clk(ADA_DCO));

   hbridge_top #(
      .BOOT_CYCLES  (BOOT_CYCLES),
      .FORCE_CYCLES (FORCE_CYCLES),
      .DT0 (DT0), .DT1 (DT1), .DT2 (DT2), .DT3 (DT3)
   ) hbridge_top_inst (
      .ADA_DCO    (ADA_DCO),
      .i_rst_n    (rst_n),
      .i_ada_data (ada_data),
      .i_adb_data (adb_data),
      .i_ada_or   (ada_or),
      .i_adb_or   (adb_or),
      .i_enable   (enable),
      .i_cmd      (cmd),
      .i_dt_sel   (dt_sel),
      .o_adc_a    (adc_a),
      .o_adc_b    (adc_b),
      .o_q        (q)
   );

   // --------------------------------------------------
   // reference functions
   // --------------------------------------------------
   function automatic hbridge_pkg::adc_sample_t adc_ref(input logic signed [W-1:0] raw,
                                                        input logic ovr);
      hbridge_pkg::adc_sample_t s;
      int neg;
      neg = -int'(raw);                          // polarity flipped on the board
      if (ovr) begin
         s.data = (int'(raw) == -FS) ? W'(FS-1) : W'(-FS);
      end else begin
         s.data = W'(neg);                       // -(-FS) wraps back to -FS
      end
      s.dac = W'(neg + hbridge_pkg::DAC_MID);    // mod 2^W by truncation
      return s;
   endfunction

   function automatic int dt_cycles(input hbridge_pkg::dt_sel_t sel);
      case (sel)
         2'd0:    return DT0;
         2'd1:    return DT1;
         2'd2:    return DT2;
         default: return DT3;
      endcase
   endfunction

   // drive pattern after the k-th enabled edge
   function automatic hbridge_pkg::bridge_t gate_ref(input int k,
                                                     input hbridge_pkg::bridge_t run_cmd);
      hbridge_pkg::bridge_t p;
      p = '0;
      if (k >= 1 && k <= BOOT_CYCLES) begin
         p.q3 = 1'b1;   // bootstrap charge
         p.q4 = 1'b1;
      end else if (k > BOOT_CYCLES && k <= BOOT_CYCLES + FORCE_CYCLES) begin
         p.q1 = 1'b1;   // sigma=1
         p.q4 = 1'b1;
      end else if (k > BOOT_CYCLES + FORCE_CYCLES) begin
         if (!((run_cmd.q1 && run_cmd.q3) || (run_cmd.q2 && run_cmd.q4))) begin
            p = run_cmd;
         end
      end
      return p;
   endfunction

   // --------------------------------------------------
   // comparing process, outputs seen at the edge are last edge's results
   // --------------------------------------------------
   always @(posedge ADA_DCO) begin
      if (!rst_n) begin
         exp_a  = '0;
         exp_b  = '0;
         exp_q  = '0;
         drv_v  = '0;
         en_cnt = 0;
         for (int i = 0; i < 4; i++) begin
            hi_cnt[i] = 0;
            dt_lat[i] = 0;   // counters empty after reset
         end
      end else begin
         checks = checks + 3;
         if (adc_a !== exp_a) begin
            errors++;
            $display("ERROR %0t: adc a got %h expected %h", $time, adc_a, exp_a);
         end
         if (adc_b !== exp_b) begin
            errors++;
            $display("ERROR %0t: adc b got %h expected %h", $time, adc_b, exp_b);
         end
         if (q !== exp_q) begin
            errors++;
            $display("ERROR %0t: o_q got %b expected %b", $time, q, exp_q);
         end
         q_next = enable ? gate_ref(en_cnt, drv_v) : '0;   // uses drv before this edge
         cmd_v  = cmd;
         for (int i = 0; i < 4; i++) begin
            if (!cmd_v[i]) begin
               drv_v[i]  = 1'b0;
               hi_cnt[i] = 0;
               dt_lat[i] = dt_cycles(dt_sel);
            end else begin
               drv_v[i] = (hi_cnt[i] + 1 >= dt_lat[i]);   // on after DTn high edges
               if (hi_cnt[i] < 255) hi_cnt[i]++;
            end
         end
         exp_q  = q_next;
         exp_a  = adc_ref(ada_data, ada_or);
         exp_b  = adc_ref(adb_data, adb_or);
         en_cnt = enable ? en_cnt + 1 : 0;
      end
   end

   // run limit
   always @(posedge ADA_DCO) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // --------------------------------------------------
   // stimulus helpers, all sampling and driving on the falling edge
   // --------------------------------------------------
   task automatic check_count(input string what, input int got, input int want);
      checks++;
      if (got != want) begin
         errors++;
         $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, want);
      end
   endtask

   task automatic check_q(input string what, input hbridge_pkg::bridge_t want);
      checks++;
      if (q !== want) begin
         errors++;
         $display("ERROR %0t: %s o_q got %b expected %b", $time, what, q, want);
      end
   endtask

   // falling edges until o_q shows pat
   task automatic wait_pattern(input hbridge_pkg::bridge_t pat, input int limit,
                               output int n);
      n = 0;
      do begin
         @(negedge ADA_DCO);
         n++;
      end while (q !== pat && n < limit);
      if (q !== pat) begin
         errors++;
         $display("o_q never showed %b within %0d cycles", pat, limit);
      end
   endtask

   // length of the run of pat that is showing now
   task automatic count_pattern(input hbridge_pkg::bridge_t pat, output int n);
      n = 1;
      @(negedge ADA_DCO);
      while (q === pat && n < 1000) begin
         n++;
         @(negedge ADA_DCO);
      end
   endtask

   task automatic wait_bit(input int b, input logic val, input int limit, output int n);
      n = 0;
      do begin
         @(negedge ADA_DCO);
         n++;
      end while (q_v[b] !== val && n < limit);
      if (q_v[b] !== val) begin
         errors++;
         $display("switch %0d never went to %b within %0d cycles", b + 1, val, limit);
      end
   endtask

   task automatic run_startup();
      int n;
      enable = 1'b1;
      wait_pattern(4'b1100, 10, n);        // q3 + q4
      check_count("edges until BOOT pattern", n, 2);
      count_pattern(4'b1100, n);
      check_count("BOOT pattern cycles", n, BOOT_CYCLES);
      count_pattern(4'b1001, n);           // q1 + q4
      check_count("FORCE pattern cycles", n, FORCE_CYCLES);
   endtask

   task automatic dead_time_check(input int sel, input int b);
      int n;
      logic [3:0] c;
      cmd    = '0;
      dt_sel = hbridge_pkg::dt_sel_t'(sel);
      repeat (2) @(negedge ADA_DCO);       // reload with the new dead time
      c    = '0;
      c[b] = 1'b1;
      cmd  = c;
      wait_bit(b, 1'b1, dt_cycles(sel) + 20, n);
      check_count("turn-on delay", n, dt_cycles(sel) + 1);
      repeat (5) @(negedge ADA_DCO);
      cmd = '0;
      wait_bit(b, 1'b0, 10, n);
      check_count("turn-off delay", n, 2);
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      int n;
      rst_n    = 1'b0;
      ada_data = '0;
      adb_data = '0;
      ada_or   = 1'b0;
      adb_or   = 1'b0;
      enable   = 1'b0;
      cmd      = '0;
      dt_sel   = '0;
      repeat (2) @(negedge ADA_DCO);
      rst_n = 1'b1;
      repeat (4) @(negedge ADA_DCO);
      check_q("disabled after reset", '0);

      // adc capture, bridge stays off
      for (int s = 0; s < 200; s++) begin
         @(negedge ADA_DCO);
         ada_data = W'($random(seed));
         adb_data = W'($random(seed));
         ada_or   = (($random(seed) & 7) == 0);   // about one in eight
         adb_or   = (($random(seed) & 7) == 0);
         if (s == 50) begin
            ada_data = W'(-FS);   // most negative with over-range
            ada_or   = 1'b1;
            adb_data = W'(-FS);
            adb_or   = 1'b0;
         end else if (s == 51) begin
            ada_data = W'(FS-1);
            ada_or   = 1'b1;
            adb_data = W'(-FS);
            adb_or   = 1'b1;
         end
      end
      @(negedge ADA_DCO);
      check_q("disabled during adc test", '0);

      // start-up, idle command afterwards
      run_startup();
      check_q("RUN with idle command", '0);

      // dead time, one switch per select value
      dead_time_check(0, 0);
      dead_time_check(1, 1);
      dead_time_check(2, 2);
      dead_time_check(3, 3);

      // shoot-through on each leg
      dt_sel = '0;
      cmd    = 4'b0101;                    // q1 + q3
      repeat (DT0 + 10) @(negedge ADA_DCO);
      check_q("leg 1 short", '0);
      cmd = '0;
      repeat (2) @(negedge ADA_DCO);
      cmd = 4'b1010;                       // q2 + q4
      repeat (DT0 + 10) @(negedge ADA_DCO);
      check_q("leg 2 short", '0);

      // enable drop and restart
      cmd = 4'b0110;                       // q2 + q3, legal
      wait_pattern(4'b0110, DT0 + 10, n);
      enable = 1'b0;
      wait_pattern('0, 5, n);
      check_count("edges until drives off", n, 1);
      repeat (5) @(negedge ADA_DCO);
      run_startup();
      check_q("RUN after restart", 4'b0110);
      cmd = '0;
      repeat (5) @(negedge ADA_DCO);

      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
